// ==== logic/cpc_pkg.sv ====
package cpc_pkg;

  // ================================================
  // Bus and register widths
  // ================================================
  typedef logic [15:0] addr_t;         // CPU and ROM address
  typedef logic [7:0]  byte_t;         // Data byte
  typedef logic [13:0] vram_addr_t;    // Video RAM address, 16 KB
  typedef logic [4:0]  hw_color_t;     // Hardware colour number
  typedef logic [3:0]  pen_t;          // Pen index
  typedef logic [1:0]  screen_mode_t;
  typedef logic [4:0]  crtc_reg_t;     // CRTC register number
  typedef logic [9:0]  scr_start_t;    // Screen start, word units

  // ================================================
  // Decoding constants
  // ================================================
  localparam int NUM_PENS = 16;

  localparam logic [1:0] GA_AREA     = 2'b01;  // Gate array at addr[15:14]
  localparam logic [1:0] LO_ROM_AREA = 2'b00;  // Lower ROM overlay
  localparam logic [1:0] HI_ROM_AREA = 2'b11;  // Upper ROM overlay and screen

  // I/O pages, address high byte
  localparam byte_t PPI_A_PAGE     = 8'hf4;
  localparam byte_t PPI_B_PAGE     = 8'hf5;
  localparam byte_t PPI_C_PAGE     = 8'hf6;
  localparam byte_t PPI_CTRL_PAGE  = 8'hf7;
  localparam byte_t CRTC_SEL_PAGE  = 8'hbc;
  localparam byte_t CRTC_DATA_PAGE = 8'hbd;

  localparam crtc_reg_t CRTC_R_START_HI = 5'd12;
  localparam crtc_reg_t CRTC_R_START_LO = 5'd13;

  localparam byte_t ROM_BANK_AMSDOS = 8'd7;   // Bank mapped to ROM chip 2
  localparam byte_t PPI_CTRL_RESET  = 8'h9b;  // Port A as input

endpackage

// ==== logic/cpu_bus_decode.sv ====
module cpu_bus_decode (
  input  logic             clk_cpu,
  input  logic             pwr_up_reset_n,
  input  cpc_pkg::addr_t   i_addr,
  input  logic             i_mreq_n,
  input  logic             i_iorq_n,
  input  logic             i_rd_n,
  input  logic             i_wr_n,
  input  cpc_pkg::byte_t   i_mem_rdata,    // Registered memory read data
  input  cpc_pkg::byte_t   i_io_rdata,     // Registered I/O read data
  output logic             o_mem_wr,
  output logic             o_mem_rd,
  output logic             o_ga_wr,
  output logic             o_rom_bank_wr,
  output logic             o_ppi_a_wr,
  output logic             o_ppi_c_wr,
  output logic             o_ppi_ctrl_wr,
  output logic             o_ppi_a_rd,
  output logic             o_ppi_b_rd,
  output logic             o_crtc_sel_wr,
  output logic             o_crtc_data_wr,
  output cpc_pkg::byte_t   o_cpu_data
);

  logic           io_wr;
  logic           io_rd;
  logic           ga_sel;
  logic           io_wr_hi;       // I/O write, not gate array, addr[13] set
  cpc_pkg::byte_t page;
  logic           mem_rd_q;       // Last bus state was a memory read
  logic           io_rd_q;        // Last bus state was an I/O read

  // Access types from the raw strobes
  assign o_mem_rd = ~i_rd_n & ~i_mreq_n;
  assign o_mem_wr = ~i_wr_n & ~i_mreq_n;
  assign io_rd    = ~i_rd_n & ~i_iorq_n;
  assign io_wr    = ~i_wr_n & ~i_iorq_n;

  assign page   = i_addr[15:8];
  assign ga_sel = (i_addr[15:14] == cpc_pkg::GA_AREA);

  // ================================================
  // I/O write selects, prioritized
  // ================================================
  assign o_ga_wr       = io_wr & ga_sel;               // Highest priority
  assign o_rom_bank_wr = io_wr & ~ga_sel & ~i_addr[13];
  assign io_wr_hi      = io_wr & ~ga_sel & i_addr[13];

  assign o_ppi_a_wr     = io_wr_hi & (page == cpc_pkg::PPI_A_PAGE);
  assign o_ppi_c_wr     = io_wr_hi & (page == cpc_pkg::PPI_C_PAGE);
  assign o_ppi_ctrl_wr  = io_wr_hi & (page == cpc_pkg::PPI_CTRL_PAGE);
  assign o_crtc_sel_wr  = io_wr_hi & (page == cpc_pkg::CRTC_SEL_PAGE);
  assign o_crtc_data_wr = io_wr_hi & (page == cpc_pkg::CRTC_DATA_PAGE);

  // Read selects, PPI only
  assign o_ppi_a_rd = io_rd & (page == cpc_pkg::PPI_A_PAGE);
  assign o_ppi_b_rd = io_rd & (page == cpc_pkg::PPI_B_PAGE);

  // ================================================
  // Read data return, one cycle behind the bus
  // ================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      mem_rd_q <= 1'b0;
      io_rd_q  <= 1'b0;
    end else begin
      mem_rd_q <= o_mem_rd;
      io_rd_q  <= io_rd & ~o_mem_rd;  // Memory wins on a double strobe
    end
  end

  assign o_cpu_data = mem_rd_q ? i_mem_rdata :
                      io_rd_q  ? i_io_rdata  : '0;  // Idle bus reads as 0

endmodule

// ==== logic/gate_array_regs.sv ====
module gate_array_regs (
  input  logic                  clk_cpu,
  input  logic                  pwr_up_reset_n,
  input  logic                  i_ga_wr,        // Gate array I/O write
  input  cpc_pkg::byte_t        i_data,
  input  cpc_pkg::pen_t         i_pen_index,    // Pen lookup from video side
  output cpc_pkg::hw_color_t    o_pen_color,
  output cpc_pkg::hw_color_t    o_border_color,
  output cpc_pkg::screen_mode_t o_mode,
  output logic                  o_lo_rom_dis,
  output logic                  o_hi_rom_dis
);

  cpc_pkg::pen_t      pen;            // Current pen for colour writes
  logic               border_sel;     // Colour writes go to the border
  cpc_pkg::hw_color_t palette [cpc_pkg::NUM_PENS];
  logic [1:0]         func;

  assign func = i_data[7:6];          // Function code

  // ================================================
  // Register writes
  // ================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      pen            <= '0;
      border_sel     <= 1'b0;
      o_border_color <= '0;
      o_mode         <= '0;
      o_lo_rom_dis   <= 1'b0;         // Both ROMs enabled
      o_hi_rom_dis   <= 1'b0;
      for (int i = 0; i < cpc_pkg::NUM_PENS; i++) begin
        palette[i] <= '0;
      end
    end else if (i_ga_wr) begin
      case (func)
        2'd0: begin                   // Pen or border select
          border_sel <= i_data[4];
          if (!i_data[4]) begin
            pen <= i_data[3:0];
          end
        end
        2'd1: begin                   // Colour write
          if (border_sel) begin
            o_border_color <= i_data[4:0];
          end else begin
            palette[pen] <= i_data[4:0];
          end
        end
        2'd2: begin                   // Mode and ROM disables
          o_hi_rom_dis <= i_data[3];
          o_lo_rom_dis <= i_data[2];
          o_mode       <= i_data[1:0];
        end
        default: begin
          // RAM banking not supported
        end
      endcase
    end
  end

  // ================================================
  // Palette lookup for the video side
  // ================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_pen_color <= '0;
    end else begin
      o_pen_color <= palette[i_pen_index];  // One cycle after the index
    end
  end

endmodule

// ==== logic/crtc_regs.sv ====
module crtc_regs (
  input  logic                clk_cpu,
  input  logic                pwr_up_reset_n,
  input  logic                i_crtc_sel_wr,   // Write to the select port
  input  logic                i_crtc_data_wr,  // Write to the data port
  input  cpc_pkg::byte_t      i_data,
  output cpc_pkg::scr_start_t o_scr_start
);

  cpc_pkg::crtc_reg_t crtc_sel;    // Selected register number

  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      crtc_sel    <= '0;
      o_scr_start <= '0;
    end else begin
      if (i_crtc_sel_wr) begin
        crtc_sel <= i_data[4:0];
      end
      // Only the screen-start pair is kept
      if (i_crtc_data_wr) begin
        if (crtc_sel == cpc_pkg::CRTC_R_START_HI) begin
          o_scr_start[9:8] <= i_data[1:0];
        end
        if (crtc_sel == cpc_pkg::CRTC_R_START_LO) begin
          o_scr_start[7:0] <= i_data;
        end
      end
    end
  end

endmodule

// ==== logic/ppi_ports.sv ====
module ppi_ports #(
  parameter cpc_pkg::byte_t PPI_B_ID = 8'h1e   // Identity byte on port B
) (
  input  logic           clk_cpu,
  input  logic           pwr_up_reset_n,
  input  logic           i_ppi_a_wr,
  input  logic           i_ppi_c_wr,
  input  logic           i_ppi_ctrl_wr,
  input  logic           i_ppi_a_rd,
  input  logic           i_ppi_b_rd,
  input  cpc_pkg::byte_t i_data,
  input  cpc_pkg::byte_t i_kbd_col,            // Keyboard column bits
  input  logic           i_vsync,
  output cpc_pkg::byte_t o_io_rdata,
  output logic [3:0]     o_kbd_row,
  output logic           o_psg_bdir,
  output logic           o_psg_bc1
);

  cpc_pkg::byte_t ppi_a;
  cpc_pkg::byte_t ppi_c;
  cpc_pkg::byte_t ppi_ctrl;
  logic           port_a_input;

  assign port_a_input = ppi_ctrl[4];

  // ================================================
  // Port latches
  // ================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      ppi_a    <= '0;
      ppi_c    <= '0;
      ppi_ctrl <= cpc_pkg::PPI_CTRL_RESET;
    end else begin
      if (i_ppi_a_wr)    ppi_a    <= i_data;
      if (i_ppi_c_wr)    ppi_c    <= i_data;
      if (i_ppi_ctrl_wr) ppi_ctrl <= i_data;
    end
  end

  // Port C drives keyboard row and PSG control
  assign o_kbd_row  = ppi_c[3:0];
  assign o_psg_bdir = ppi_c[7];
  assign o_psg_bc1  = ppi_c[6];

  // Read data, one cycle latency
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_io_rdata <= '0;
    end else if (i_ppi_a_rd) begin
      o_io_rdata <= port_a_input ? i_kbd_col : ppi_a;
    end else if (i_ppi_b_rd) begin
      o_io_rdata <= {PPI_B_ID[7:1], i_vsync};  // Vsync in bit 0
    end else begin
      o_io_rdata <= '0;
    end
  end

endmodule

// ==== logic/memory_map.sv ====
module memory_map (
  input  logic                clk_cpu,
  input  logic                pwr_up_reset_n,
  input  cpc_pkg::addr_t      i_addr,
  input  cpc_pkg::byte_t      i_data,
  input  logic                i_mem_wr,
  input  logic                i_mem_rd,
  input  logic                i_rom_bank_wr,  // Upper ROM bank select write
  input  logic                i_lo_rom_dis,
  input  logic                i_hi_rom_dis,
  input  cpc_pkg::byte_t      i_rom_data,     // Same-cycle ROM data
  input  cpc_pkg::scr_start_t i_scr_start,
  input  cpc_pkg::vram_addr_t i_vid_addr,
  output cpc_pkg::byte_t      o_mem_rdata,
  output cpc_pkg::addr_t      o_rom_addr,
  output cpc_pkg::byte_t      o_vid_data
);

  cpc_pkg::byte_t ram [2**16];     // Full 64 KB, ROMs overlay on read
  cpc_pkg::byte_t rom_bank;
  logic [1:0]     area;
  logic [1:0]     rom_chip;
  logic           rom_sel;
  logic [10:0]    vid_ofs;
  cpc_pkg::addr_t vid_ram_addr;

  assign area = i_addr[15:14];

  // ================================================
  // ROM overlay mapping
  // ================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      rom_bank <= '0;
    end else if (i_rom_bank_wr) begin
      rom_bank <= i_data;
    end
  end

  // Chip 0 is the OS, chip 1 BASIC, chip 2 AMSDOS
  assign rom_chip = (area == cpc_pkg::LO_ROM_AREA)         ? 2'd0 :
                    (rom_bank == cpc_pkg::ROM_BANK_AMSDOS) ? 2'd2 : 2'd1;
  assign o_rom_addr = {rom_chip, i_addr[13:0]};

  assign rom_sel = ((area == cpc_pkg::LO_ROM_AREA) && !i_lo_rom_dis) ||
                   ((area == cpc_pkg::HI_ROM_AREA) && !i_hi_rom_dis);

  // ================================================
  // CPU side of the RAM
  // ================================================
  always_ff @(posedge clk_cpu) begin
    if (i_mem_wr) begin
      ram[i_addr] <= i_data;       // Writes land under the ROMs too
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_mem_rd) begin
      o_mem_rdata <= rom_sel ? i_rom_data : ram[i_addr];
    end
  end

  // ================================================
  // Video read port
  // ================================================
  // Screen start counts words, so double it
  assign vid_ofs      = i_vid_addr[10:0] + {i_scr_start, 1'b0};  // Wraps in 2 KB
  assign vid_ram_addr = {cpc_pkg::HI_ROM_AREA, i_vid_addr[13:11], vid_ofs};

  always_ff @(posedge clk_cpu) begin
    o_vid_data <= ram[vid_ram_addr];  // Top 16 KB of RAM
  end

endmodule

// ==== logic/cpc_bus_top.sv ====
module cpc_bus_top #(
  parameter cpc_pkg::byte_t PPI_B_ID = 8'h1e
) (
  input  logic                  clk_cpu,
  input  logic                  pwr_up_reset_n,
  // Z80 bus
  input  cpc_pkg::addr_t        i_addr,
  input  cpc_pkg::byte_t        i_data,
  input  logic                  i_mreq_n,
  input  logic                  i_iorq_n,
  input  logic                  i_rd_n,
  input  logic                  i_wr_n,
  output cpc_pkg::byte_t        o_cpu_data,
  // External ROM
  input  cpc_pkg::byte_t        i_rom_data,
  output cpc_pkg::addr_t        o_rom_addr,
  // Keyboard, PSG and video side
  input  cpc_pkg::byte_t        i_kbd_col,
  input  logic                  i_vsync,
  input  cpc_pkg::pen_t         i_pen_index,
  input  cpc_pkg::vram_addr_t   i_vid_addr,
  output cpc_pkg::byte_t        o_vid_data,
  output cpc_pkg::hw_color_t    o_pen_color,
  output cpc_pkg::hw_color_t    o_border_color,
  output cpc_pkg::screen_mode_t o_mode,
  output logic [3:0]            o_kbd_row,
  output logic                  o_psg_bdir,
  output logic                  o_psg_bc1
);

  // ================================================
  // Decode selects and return data
  // ================================================
  logic                mem_wr;
  logic                mem_rd;
  logic                ga_wr;
  logic                rom_bank_wr;
  logic                ppi_a_wr;
  logic                ppi_c_wr;
  logic                ppi_ctrl_wr;
  logic                ppi_a_rd;
  logic                ppi_b_rd;
  logic                crtc_sel_wr;
  logic                crtc_data_wr;
  cpc_pkg::byte_t      mem_rdata;
  cpc_pkg::byte_t      io_rdata;
  logic                lo_rom_dis;
  logic                hi_rom_dis;
  cpc_pkg::scr_start_t scr_start;

  cpu_bus_decode cpu_bus_decode_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_addr         (i_addr),
    .i_mreq_n       (i_mreq_n),
    .i_iorq_n       (i_iorq_n),
    .i_rd_n         (i_rd_n),
    .i_wr_n         (i_wr_n),
    .i_mem_rdata    (mem_rdata),
    .i_io_rdata     (io_rdata),
    .o_mem_wr       (mem_wr),
    .o_mem_rd       (mem_rd),
    .o_ga_wr        (ga_wr),
    .o_rom_bank_wr  (rom_bank_wr),
    .o_ppi_a_wr     (ppi_a_wr),
    .o_ppi_c_wr     (ppi_c_wr),
    .o_ppi_ctrl_wr  (ppi_ctrl_wr),
    .o_ppi_a_rd     (ppi_a_rd),
    .o_ppi_b_rd     (ppi_b_rd),
    .o_crtc_sel_wr  (crtc_sel_wr),
    .o_crtc_data_wr (crtc_data_wr),
    .o_cpu_data     (o_cpu_data)
  );

  gate_array_regs gate_array_regs_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_ga_wr        (ga_wr),
    .i_data         (i_data),
    .i_pen_index    (i_pen_index),
    .o_pen_color    (o_pen_color),
    .o_border_color (o_border_color),
    .o_mode         (o_mode),
    .o_lo_rom_dis   (lo_rom_dis),
    .o_hi_rom_dis   (hi_rom_dis)
  );

  crtc_regs crtc_regs_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_crtc_sel_wr  (crtc_sel_wr),
    .i_crtc_data_wr (crtc_data_wr),
    .i_data         (i_data),
    .o_scr_start    (scr_start)
  );

  ppi_ports #(
    .PPI_B_ID (PPI_B_ID)
  ) ppi_ports_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_ppi_a_wr     (ppi_a_wr),
    .i_ppi_c_wr     (ppi_c_wr),
    .i_ppi_ctrl_wr  (ppi_ctrl_wr),
    .i_ppi_a_rd     (ppi_a_rd),
    .i_ppi_b_rd     (ppi_b_rd),
    .i_data         (i_data),
    .i_kbd_col      (i_kbd_col),
    .i_vsync        (i_vsync),
    .o_io_rdata     (io_rdata),
    .o_kbd_row      (o_kbd_row),
    .o_psg_bdir     (o_psg_bdir),
    .o_psg_bc1      (o_psg_bc1)
  );

  // RAM, ROM overlay and screen fetch
  memory_map memory_map_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_addr         (i_addr),
    .i_data         (i_data),
    .i_mem_wr       (mem_wr),
    .i_mem_rd       (mem_rd),
    .i_rom_bank_wr  (rom_bank_wr),
    .i_lo_rom_dis   (lo_rom_dis),
    .i_hi_rom_dis   (hi_rom_dis),
    .i_rom_data     (i_rom_data),
    .i_scr_start    (scr_start),
    .i_vid_addr     (i_vid_addr),
    .o_mem_rdata    (mem_rdata),
    .o_rom_addr     (o_rom_addr),
    .o_vid_data     (o_vid_data)
  );

endmodule

// ==== verif/cpc_bus_tb.sv ====
module cpc_bus_tb;

  localparam int         NUM_CYCLES     = 4000;
  localparam int         TIMEOUT_CYCLES = 2 * NUM_CYCLES + 100;
  localparam logic [7:0] B_ID           = 8'ha5;   // PPI port B identity, bit 0 set

  // Bus state kinds
  localparam logic [2:0] KIND_IDLE   = 3'd0;
  localparam logic [2:0] KIND_MEM_WR = 3'd1;
  localparam logic [2:0] KIND_MEM_RD = 3'd2;
  localparam logic [2:0] KIND_IO_WR  = 3'd3;
  localparam logic [2:0] KIND_IO_RD  = 3'd4;

  logic        clk_cpu;
  logic        pwr_up_reset_n;
  logic [15:0] addr;
  logic [7:0]  data;
  logic        mreq_n, iorq_n, rd_n, wr_n;
  logic [7:0]  cpu_data;
  logic [7:0]  rom_data;
  logic [15:0] rom_addr;
  logic [7:0]  kbd_col;
  logic        vsync;
  logic [3:0]  pen_index;
  logic [13:0] vid_addr;
  logic [7:0]  vid_data;
  logic [4:0]  pen_color, border_color;
  logic [1:0]  mode;
  logic [3:0]  kbd_row;
  logic        psg_bdir, psg_bc1;

  int seed;
  int errors      = 0;
  int checks      = 0;
  int cycle_count = 0;

  // Current bus state, as driven
  logic [2:0]  s_kind;
  logic [15:0] s_addr;
  logic [7:0]  s_data, s_kbd;
  logic        s_vsync;
  logic [3:0]  s_pen_idx;
  logic [13:0] s_vid_addr;

  // ==================================================
  // Reference model state
  // ==================================================
  logic [7:0] ram_model [65536];
  bit         ram_valid [65536];        // Set once an address is written
  logic [4:0] m_palette [16];
  logic [3:0] m_pen;
  logic       m_border_sel, m_lo_dis, m_hi_dis;
  logic [4:0] m_border;
  logic [1:0] m_mode;
  logic [7:0] m_rom_bank, m_ppi_a, m_ppi_c, m_ppi_ctrl;
  logic [4:0] m_crtc_sel;
  logic [9:0] m_scr_start;

  cpc_bus_top #(.PPI_B_ID(B_ID)) cpc_bus_top_i (
    .clk_cpu (clk_cpu), .pwr_up_reset_n (pwr_up_reset_n),
    .i_addr (addr), .i_data (data), .i_mreq_n (mreq_n), .i_iorq_n (iorq_n),
    .i_rd_n (rd_n), .i_wr_n (wr_n), .o_cpu_data (cpu_data),
    .i_rom_data (rom_data), .o_rom_addr (rom_addr),
    .i_kbd_col (kbd_col), .i_vsync (vsync), .i_pen_index (pen_index),
    .i_vid_addr (vid_addr), .o_vid_data (vid_data), .o_pen_color (pen_color),
    .o_border_color (border_color), .o_mode (mode), .o_kbd_row (kbd_row),
    .o_psg_bdir (psg_bdir), .o_psg_bc1 (psg_bc1)
  );

  // ROM contents, low byte XOR high byte of the ROM address
  function automatic logic [7:0] rom_byte(input logic [15:0] a);
    return a[7:0] ^ a[15:8];
  endfunction

  assign rom_data = rom_byte(rom_addr);  // Combinational external ROM

  initial begin
    clk_cpu = 1'b0;
    forever #20 clk_cpu = ~clk_cpu;
  end

  // Run limit
  always @(posedge clk_cpu) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s at cycle %0d: expected %0h, actual %0h",
               name, cycle_count, expected, actual);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic make_stimulus;
    logic [31:0] r, r2;
    logic [7:0]  page;
    logic [10:0] ofs;
    r  = $random(seed);
    r2 = $random(seed);
    s_data = r2[7:0];
    case (r[2:0])
      3'd0, 3'd1: s_kind = KIND_MEM_WR;
      3'd2, 3'd3: s_kind = KIND_MEM_RD;
      3'd4, 3'd5: s_kind = KIND_IO_WR;
      3'd6:       s_kind = KIND_IO_RD;
      default:    s_kind = KIND_IDLE;
    endcase
    if (s_kind == KIND_IO_WR) begin
      case (r[5:3])                     // Bias toward decoded pages
        3'd0:    page = 8'h7f;          // Gate array
        3'd1:    page = 8'hdf;          // ROM bank
        3'd2:    page = 8'hf4;
        3'd3:    page = 8'hf6;
        3'd4:    page = 8'hf7;
        3'd5:    page = 8'hbc;
        3'd6:    page = 8'hbd;
        default: page = r[15:8];
      endcase
      if (page == 8'hbc && r2[9:8] != 2'b00) s_data = {3'b000, r2[10] ? 5'd13 : 5'd12};
      if (page == 8'hdf && r2[8]) s_data = 8'd7;  // AMSDOS bank often
      s_addr = {page, r[23:16]};
    end else if (s_kind == KIND_IO_RD) begin
      page   = r[4] ? (r[3] ? 8'hf5 : 8'hf4) : r[15:8];
      s_addr = {page, r[23:16]};
    end else begin
      s_addr = r[31:16];
      if (r[4:3] != 2'b00) s_addr[13:5] = '0;  // Crowd into small windows
    end
    r = $random(seed);
    s_kbd     = r[7:0];
    s_vsync   = r[8];
    s_pen_idx = r[12:9];
    // Aim half the video fetches at the written window above c000
    ofs = {6'b000000, r[17:13]} - {m_scr_start, 1'b0};
    s_vid_addr = r[18] ? {3'b000, ofs} : r[31:18];
  endtask

  task automatic drive_bus;
    addr      = s_addr;
    data      = s_data;
    mreq_n    = !(s_kind == KIND_MEM_WR || s_kind == KIND_MEM_RD);
    iorq_n    = !(s_kind == KIND_IO_WR || s_kind == KIND_IO_RD);
    wr_n      = !(s_kind == KIND_MEM_WR || s_kind == KIND_IO_WR);
    rd_n      = !(s_kind == KIND_MEM_RD || s_kind == KIND_IO_RD);
    kbd_col   = s_kbd;
    vsync     = s_vsync;
    pen_index = s_pen_idx;
    vid_addr  = s_vid_addr;
  endtask

  // ==================================================
  // Model updates and checks
  // ==================================================
  task automatic apply_io_write(input logic [15:0] a, input logic [7:0] d);
    if (a[15:14] == 2'b01) begin        // Gate array first
      case (d[7:6])
        2'd0: begin
          m_border_sel = d[4];
          if (!d[4]) m_pen = d[3:0];
        end
        2'd1: begin
          if (m_border_sel) m_border = d[4:0];
          else m_palette[m_pen] = d[4:0];
        end
        2'd2: begin
          m_hi_dis = d[3];
          m_lo_dis = d[2];
          m_mode   = d[1:0];
        end
        default: ;
      endcase
    end else if (!a[13]) begin
      m_rom_bank = d;
    end else begin
      case (a[15:8])
        8'hf4: m_ppi_a    = d;
        8'hf6: m_ppi_c    = d;
        8'hf7: m_ppi_ctrl = d;
        8'hbc: m_crtc_sel = d[4:0];
        8'hbd: begin
          if (m_crtc_sel == 5'd12) m_scr_start[9:8] = d[1:0];
          if (m_crtc_sel == 5'd13) m_scr_start[7:0] = d;
        end
        default: ;
      endcase
    end
  endtask

  task automatic step_model;
    logic [1:0]  chip;
    logic [15:0] vid_ram;
    logic [7:0]  exp_cpu;
    logic        cpu_known;
    logic [4:0]  exp_pen;
    string       name;
    exp_cpu   = 8'h00;
    cpu_known = 1'b1;
    name      = "idle_bus";
    chip      = (m_rom_bank == 8'd7) ? 2'd2 : 2'd1;
    if (s_kind == KIND_MEM_RD) begin
      name = "mem_read";
      if (s_addr[15:14] == 2'b00 && !m_lo_dis) begin
        exp_cpu = rom_byte({2'b00, s_addr[13:0]});
      end else if (s_addr[15:14] == 2'b11 && !m_hi_dis) begin
        exp_cpu = rom_byte({chip, s_addr[13:0]});
      end else begin
        exp_cpu   = ram_model[s_addr];
        cpu_known = ram_valid[s_addr];
      end
    end else if (s_kind == KIND_IO_RD) begin
      name = "io_read";
      case (s_addr[15:8])
        8'hf4:   exp_cpu = m_ppi_ctrl[4] ? s_kbd : m_ppi_a;
        8'hf5:   exp_cpu = {B_ID[7:1], s_vsync};
        default: exp_cpu = 8'h00;
      endcase
    end
    exp_pen = m_palette[s_pen_idx];
    vid_ram = {2'b11, s_vid_addr[13:11], s_vid_addr[10:0] + {m_scr_start, 1'b0}};
    // Video fetch and pen lookup see state before the edge
    if (ram_valid[vid_ram]) check_value("vid_data", 32'(ram_model[vid_ram]), 32'(vid_data));
    check_value("pen_color", 32'(exp_pen), 32'(pen_color));
    if (cpu_known) check_value(name, 32'(exp_cpu), 32'(cpu_data));
    if (s_kind == KIND_MEM_WR) begin
      ram_model[s_addr] = s_data;
      ram_valid[s_addr] = 1'b1;
    end
    if (s_kind == KIND_IO_WR) apply_io_write(s_addr, s_data);
    check_value("border_color", 32'(m_border), 32'(border_color));
    check_value("mode", 32'(m_mode), 32'(mode));
    check_value("kbd_row", 32'(m_ppi_c[3:0]), 32'(kbd_row));
    check_value("psg_bdir", 32'(m_ppi_c[7]), 32'(psg_bdir));
    check_value("psg_bc1", 32'(m_ppi_c[6]), 32'(psg_bc1));
  endtask

  initial begin
    seed           = 32'haf53;
    pwr_up_reset_n = 1'b0;
    s_kind         = KIND_IDLE;
    s_addr         = '0;
    s_data         = '0;
    s_kbd          = '0;
    s_vsync        = 1'b0;
    s_pen_idx      = '0;
    s_vid_addr     = '0;
    drive_bus();                        // Strobes idle high
    for (int i = 0; i < 16; i++) m_palette[i] = '0;
    m_pen          = '0;
    m_border_sel   = 1'b0;
    m_lo_dis       = 1'b0;
    m_hi_dis       = 1'b0;
    m_border       = '0;
    m_mode         = '0;
    m_rom_bank     = '0;
    m_ppi_a        = '0;
    m_ppi_c        = '0;
    m_ppi_ctrl     = 8'h9b;
    m_crtc_sel     = '0;
    m_scr_start    = '0;
    repeat (8) @(posedge clk_cpu);
    #2 pwr_up_reset_n = 1'b1;
    // Reset values before the first live edge
    check_value("reset_cpu_data", 32'h0, 32'(cpu_data));
    check_value("reset_pen_color", 32'h0, 32'(pen_color));
    check_value("reset_border", 32'h0, 32'(border_color));
    check_value("reset_mode", 32'h0, 32'(mode));
    check_value("reset_kbd_row", 32'h0, 32'(kbd_row));
    check_value("reset_psg", 32'h0, 32'({psg_bdir, psg_bc1}));
    for (int n = 0; n < NUM_CYCLES; n++) begin
      make_stimulus();
      drive_bus();
      @(posedge clk_cpu);
      #2;
      step_model();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== cpc_bus_top.f ====
logic/cpc_pkg.sv
logic/cpu_bus_decode.sv
logic/gate_array_regs.sv
logic/crtc_regs.sv
logic/ppi_ports.sv
logic/memory_map.sv
logic/cpc_bus_top.sv
verif/cpc_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cpc_bus testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary -sv -f cpc_bus_top.f --top-module cpc_bus_tb -Mdir obj_dir -o cpc_bus_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpc_bus_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^>>> PASS$" "$log_file"; then
  exit 0
fi
exit 1
